// ==== bench/zxuno_bus_chk.sv ====
`timescale 1ns/1ps

module zxuno_bus_chk (
   input logic clk,
   input logic rst_n,
   input logic iorq_n,
   input logic rd_n,
   input logic oe_n,
   input logic regaddr_changed
);

   int unsigned fails = 0;   // Failed assertions so far

   //////////////////////////////////////////////////////////////////////
   // Bus read enable
   //////////////////////////////////////////////////////////////////////

   // Data driven only inside an I/O read
   a_oe_in_read: assert property (@(posedge clk) disable iff (!rst_n)
                                  !oe_n |-> (!iorq_n && !rd_n))
      else begin
         fails++;
         $error("oe_n low outside an I/O read cycle");
      end

   // Bus released during reset
   a_oe_reset: assert property (@(posedge clk) !rst_n |-> oe_n)
      else begin
         fails++;
         $error("oe_n low while rst_n is low");
      end

   // Select pulse lasts a single clock
   a_select_pulse: assert property (@(posedge clk) disable iff (!rst_n)
                                    regaddr_changed |=> !regaddr_changed)
      else begin
         fails++;
         $error("regaddr_changed high for more than one cycle");
      end

endmodule

bind zxuno_bus zxuno_bus_chk i_zxuno_bus_chk (
   .clk(clk),
   .rst_n(rst_n),
   .iorq_n(iorq_n),
   .rd_n(rd_n),
   .oe_n(oe_n),
   .regaddr_changed(regaddr_changed)
);

// ==== bench/zxuno_bus_tb.sv ====
`timescale 1ns/1ps

`include "zxuno_defines.svh"

module zxuno_bus_tb;

   logic        clk;
   logic        rst_n;
   logic [15:0] a;
   logic        iorq_n;
   logic        rd_n;
   logic        wr_n;
   logic [7:0]  din;
   logic [7:0]  dout;
   logic        oe_n;
   logic [4:0]  kbdjoy_in;    // Active high
   logic [4:0]  db9joy_in;    // Active low
   logic [4:0]  kbdcol_in;
   logic [4:0]  kbdcol_out;
   logic        vertical_retrace_int_n;

   int          seed = 32'h384e3a90;
   int          errors;        // Whole run
   int          test_errors;   // Current test only
   int          tests;
   string       id_text = "T01-2024";
   logic [7:0]  model_conf;    // JOYCONF as last written
   logic        model_phase;   // Autofire gate
   logic [7:0]  rd_data;
   logic        rd_oe_n;
   logic [7:0]  rnd;

   zxuno_bus i_zxuno_bus (
      .clk(clk), .rst_n(rst_n),
      .a(a), .iorq_n(iorq_n), .rd_n(rd_n), .wr_n(wr_n),
      .din(din), .dout(dout), .oe_n(oe_n),
      .kbdjoy_in(kbdjoy_in), .db9joy_in(db9joy_in),
      .kbdcol_in(kbdcol_in), .kbdcol_out(kbdcol_out),
      .vertical_retrace_int_n(vertical_retrace_int_n)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;   // 100 MHz
   end

   //////////////////////////////////////////////////////////////////////
   // Clock and bus cycles
   //////////////////////////////////////////////////////////////////////

   // One clock edge within 100 ns
   task automatic next_edge(input bit falling);
      fork
         if (falling) @(negedge clk);
         else @(posedge clk);
         begin
            #100;
            $display("Timeout, no clock edge within 100 ns");
            $display("Verification failed");
            $finish;
         end
      join_any
      disable fork;
   endtask

   task automatic wait_clocks(input int n);
      for (int i = 0; i < n; i++)
         next_edge(1'b0);
   endtask

   // Strobes low 3 clocks then idle 2
   task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
      a      <= addr;
      din    <= data;
      iorq_n <= 1'b0;
      wr_n   <= 1'b0;
      wait_clocks(3);
      iorq_n <= 1'b1;
      wr_n   <= 1'b1;
      wait_clocks(2);
   endtask

   task automatic io_read(input logic [15:0] addr, output logic [7:0] data, output logic oe);
      a      <= addr;
      iorq_n <= 1'b0;
      rd_n   <= 1'b0;
      wait_clocks(2);
      next_edge(1'b1);   // Mid cycle with the bus settled
      data = dout;
      oe   = oe_n;
      wait_clocks(1);
      iorq_n <= 1'b1;
      rd_n   <= 1'b1;
      wait_clocks(2);
   endtask

   task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
      if (got !== exp) begin
         $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
         test_errors++;
      end
   endtask

   task automatic end_test(input string name);
      tests++;
      errors += test_errors;
      $display("test %0d %s: %s, %0d errors", tests, name,
               (test_errors == 0) ? "pass" : "fail", test_errors);
      test_errors = 0;
   endtask

   //////////////////////////////////////////////////////////////////////
   // Reference model
   //////////////////////////////////////////////////////////////////////

   // Expected ID byte for the n-th read with the terminator after the text
   function automatic logic [7:0] id_char(input int n);
      int p;
      p = n % `COREID_LEN;
      return (p < id_text.len()) ? id_text[p] : 8'h00;
   endfunction

   // Active high joystick state as {fire, up, down, left, right}
   function automatic logic [4:0] joy_state(input logic [4:0] raw, input logic low_active,
                                            input logic autofire, input logic phase);
      logic [4:0] st;
      st = low_active ? ~raw : raw;
      if (autofire && !phase)
         st[4] = 1'b0;   // Fire masked in the closed phase
      return st;
   endfunction

   function automatic logic [7:0] ref_kempston(input logic [7:0] conf, input logic [4:0] kj,
                                              input logic [4:0] dj, input logic phase);
      logic [4:0] bits;
      bits = '0;
      if (conf[2:0] == zxuno_pkg::JOY_KEMPSTON)
         bits = bits | joy_state(kj, 1'b0, conf[3], phase);
      if (conf[6:4] == zxuno_pkg::JOY_KEMPSTON)
         bits = bits | joy_state(dj, 1'b1, conf[7], phase);
      return {3'b000, bits};
   endfunction

   // Column bits one joystick pulls low
   function automatic logic [4:0] keys_down(input logic [2:0] mode, input logic [4:0] st,
                                            input logic a12, input logic a11);
      logic [4:0] k;
      k = '0;
      if (mode == zxuno_pkg::JOY_SINCLAIR1 && !a12) begin
         k[0] = st[4];   // Fire
         k[1] = st[3];
         k[2] = st[2];
         k[3] = st[0];   // Right
         k[4] = st[1];
      end
      if (mode == zxuno_pkg::JOY_CURSOR && !a12) begin
         k[0] = st[4];
         k[2] = st[0];
         k[3] = st[3];   // Up
         k[4] = st[2];
      end
      if (mode == zxuno_pkg::JOY_CURSOR && !a11)
         k[4] = k[4] | st[1];   // Left on the other half row
      return k;
   endfunction

   function automatic logic [4:0] ref_cols(input logic [7:0] conf, input logic [4:0] kj,
                                           input logic [4:0] dj, input logic phase,
                                           input logic [4:0] cols, input logic [15:0] addr);
      logic [4:0] down;
      down = keys_down(conf[2:0], joy_state(kj, 1'b0, conf[3], phase), addr[12], addr[11]) |
             keys_down(conf[6:4], joy_state(dj, 1'b1, conf[7], phase), addr[12], addr[11]);
      return cols & ~down;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////////////////////////

   initial begin
      logic [7:0] conf;
      int         k;
      rst_n                  = 1'b0;
      a                      = '0;
      iorq_n                 = 1'b1;
      rd_n                   = 1'b1;
      wr_n                   = 1'b1;
      din                    = '0;
      kbdjoy_in              = '0;
      db9joy_in              = '1;   // Released
      kbdcol_in              = '1;
      vertical_retrace_int_n = 1'b1;
      errors      = 0;
      test_errors = 0;
      tests       = 0;
      model_conf  = `JOYCONF_RESET;
      model_phase = 1'b1;
      wait_clocks(2);
      rst_n <= 1'b1;
      wait_clocks(1);

      io_read(`ZXUNO_ADDR_PORT, rd_data, rd_oe_n);
      check("dout", rd_data, 8'h00);
      check("oe_n", rd_oe_n, 1'b0);
      io_write(`ZXUNO_ADDR_PORT, `REG_JOYCONF);
      io_read(`ZXUNO_DATA_PORT, rd_data, rd_oe_n);
      check("joyconf", rd_data, `JOYCONF_RESET);
      io_read(16'h00FE, rd_data, rd_oe_n);   // Nothing decodes this
      check("dout", rd_data, 8'hFF);
      check("oe_n", rd_oe_n, 1'b1);
      end_test("reset values");

      for (k = 0; k < 8; k++) begin
         rnd = $random(seed);
         io_write(`ZXUNO_ADDR_PORT, rnd);
         io_read(`ZXUNO_ADDR_PORT, rd_data, rd_oe_n);
         check("zxuno_addr", rd_data, rnd);
      end
      end_test("address register");

      io_write(`ZXUNO_ADDR_PORT, `REG_COREID);
      for (k = 0; k < 20; k++) begin
         io_read(`ZXUNO_DATA_PORT, rd_data, rd_oe_n);
         check("coreid", rd_data, id_char(k));
      end
      io_write(`ZXUNO_ADDR_PORT, `REG_COREID);   // Reselect mid string restarts the text
      io_read(`ZXUNO_DATA_PORT, rd_data, rd_oe_n);
      check("coreid", rd_data, id_char(0));
      end_test("core id");

      io_write(`ZXUNO_ADDR_PORT, `REG_JOYCONF);
      for (k = 0; k < 16; k++) begin
         conf = $random(seed);
         if (k % 2 == 0)
            conf = conf & 8'hBB;   // Modes 0 to 3 only
         io_write(`ZXUNO_DATA_PORT, conf);
         model_conf = conf;
         io_read(`ZXUNO_DATA_PORT, rd_data, rd_oe_n);
         check("joyconf", rd_data, model_conf);
         kbdjoy_in <= $random(seed);
         db9joy_in <= $random(seed);
         rnd = $random(seed);
         io_read({rnd, `KEMPSTON_PORT}, rd_data, rd_oe_n);
         check("kempston", rd_data, ref_kempston(model_conf, kbdjoy_in, db9joy_in, model_phase));
         check("oe_n", rd_oe_n, 1'b0);
      end
      end_test("joyconf kempston");

      for (k = 0; k < 24; k++) begin
         conf      = $random(seed);
         conf[2:0] = {2'b01, conf[0]};   // Sinclair1 or cursor
         conf[6:4] = {2'b01, conf[4]};
         io_write(`ZXUNO_DATA_PORT, conf);
         model_conf = conf;
         kbdjoy_in <= $random(seed);
         db9joy_in <= $random(seed);
         kbdcol_in <= $random(seed);
         a         <= $random(seed);   // Row select on a[12] and a[11]
         next_edge(1'b1);
         check("kbdcol_out", kbdcol_out,
               ref_cols(model_conf, kbdjoy_in, db9joy_in, model_phase, kbdcol_in, a));
         next_edge(1'b0);
      end
      end_test("key injection");

      io_write(`ZXUNO_DATA_PORT, 8'h99);   // Both Kempston with autofire
      model_conf = 8'h99;
      for (k = 0; k < 8; k++) begin
         kbdjoy_in <= (k % 2) ? 5'b10000 : 5'b00000;   // Fire alternates joysticks
         db9joy_in <= (k % 2) ? 5'b11111 : 5'b01111;
         vertical_retrace_int_n <= 1'b0;
         model_phase = ~model_phase;
         wait_clocks(2);
         vertical_retrace_int_n <= 1'b1;
         wait_clocks(1);
         io_read({8'h00, `KEMPSTON_PORT}, rd_data, rd_oe_n);
         check("kempston", rd_data, ref_kempston(model_conf, kbdjoy_in, db9joy_in, model_phase));
         check("fire", rd_data[4], model_phase);
      end
      end_test("autofire");

      errors += i_zxuno_bus.i_zxuno_bus_chk.fails;   // Assertion failures
      $display("tests %0d, errors %0d", tests, errors);
      if (errors == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

endmodule

// ==== source/coreid.sv ====
`timescale 1ns/1ps

`include "zxuno_defines.svh"

module coreid (
   input  logic                 clk,
   input  logic                 rst_n,
   input  zxuno_pkg::reg_addr_t zxuno_addr,
   input  logic                 zxuno_regrd,
   input  logic                 regaddr_changed,
   output logic [7:0]           dout,
   output logic                 oe_n
);

   logic [3:0] char_idx;   // Next character to return
   logic [7:0] id_char;
   logic       id_rd;      // Data port read of this register
   logic       id_rd_q;

   assign id_rd = zxuno_regrd && (zxuno_addr == `REG_COREID);

   //////////////////////////////////////////////////////////////////////
   // ID text with zero terminator
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      case (char_idx)
         4'd0:    id_char = "T";
         4'd1:    id_char = "0";
         4'd2:    id_char = "1";
         4'd3:    id_char = "-";
         4'd4:    id_char = "2";
         4'd5:    id_char = "0";
         4'd6:    id_char = "2";
         4'd7:    id_char = "4";
         default: id_char = 8'h00;   // Terminator
      endcase
   end

   assign dout = id_char;
   assign oe_n = !id_rd;

   //////////////////////////////////////////////////////////////////////
   // Character index
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         id_rd_q  <= 1'b0;
         char_idx <= '0;
      end else begin
         id_rd_q <= id_rd;
         if (regaddr_changed) begin
            char_idx <= '0;   // Reselect restarts the text
         end else if (id_rd_q && !id_rd) begin
            // Step at the end of each read and wrap after the terminator
            if (char_idx == 4'(`COREID_LEN - 1))
               char_idx <= '0;
            else
               char_idx <= char_idx + 4'd1;
         end
      end
   end

endmodule

// ==== source/joy_config.sv ====
`timescale 1ns/1ps

`include "zxuno_defines.svh"

module joy_config (
   input  logic                 clk,
   input  logic                 rst_n,
   input  zxuno_pkg::reg_addr_t zxuno_addr,
   input  logic                 zxuno_regrd,
   input  logic                 zxuno_regwr,
   input  logic [7:0]           din,
   output logic [7:0]           dout,
   output logic                 oe_n,
   // Decoded fields for the mapper
   output zxuno_pkg::joy_mode_t kbd_mode,
   output logic                 kbd_autofire,
   output zxuno_pkg::joy_mode_t db9_mode,
   output logic                 db9_autofire
);

   logic [7:0] joyconf;   // {db9 af, db9 mode, kbd af, kbd mode}
   logic       sel;

   // Unknown codes fall back to off
   function automatic zxuno_pkg::joy_mode_t decode_mode(input logic [2:0] code);
      zxuno_pkg::joy_mode_t mode;
      case (code)
         3'd1:    mode = zxuno_pkg::JOY_KEMPSTON;
         3'd2:    mode = zxuno_pkg::JOY_SINCLAIR1;
         3'd3:    mode = zxuno_pkg::JOY_CURSOR;
         default: mode = zxuno_pkg::JOY_OFF;
      endcase
      return mode;
   endfunction

   assign sel = (zxuno_addr == `REG_JOYCONF);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         joyconf <= `JOYCONF_RESET;
      end else if (zxuno_regwr && sel) begin
         joyconf <= din;
      end
   end

   // Raw value back including unknown codes
   assign dout = joyconf;
   assign oe_n = !(zxuno_regrd && sel);

   assign kbd_mode     = decode_mode(joyconf[2:0]);
   assign kbd_autofire = joyconf[3];
   assign db9_mode     = decode_mode(joyconf[6:4]);
   assign db9_autofire = joyconf[7];

endmodule

// ==== source/joystick_mapper.sv ====
`timescale 1ns/1ps

`include "zxuno_defines.svh"

module joystick_mapper (
   input  logic                 clk,
   input  logic                 rst_n,
   // Z80 bus
   input  logic [15:0]          a,
   input  logic                 iorq_n,
   input  logic                 rd_n,
   input  logic                 wr_n,
   // Joysticks in the order fire up down left right
   input  logic [4:0]           kbdjoy_in,   // Active high
   input  logic [4:0]           db9joy_in,   // Active low
   // Keyboard columns towards the ULA
   input  logic [4:0]           kbdcol_in,
   output logic [4:0]           kbdcol_out,
   input  logic                 vertical_retrace_int_n,  // Autofire time base
   // Configuration
   input  zxuno_pkg::joy_mode_t kbd_mode,
   input  logic                 kbd_autofire,
   input  zxuno_pkg::joy_mode_t db9_mode,
   input  logic                 db9_autofire,
   // Kempston readback
   output logic [7:0]           dout,
   output logic                 oe_n
);

   logic       int_n_q;     // Interrupt line one clock late
   logic       fire_phase;  // Autofire gate
   logic [4:0] kbd_state;   // Active high with fire gated
   logic [4:0] db9_state;
   logic [4:0] kemp_bits;
   logic [4:0] kbd_mask;    // Column bits to pull low
   logic [4:0] db9_mask;

   //////////////////////////////////////////////////////////////////////
   // Autofire phase
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         int_n_q    <= 1'b1;
         fire_phase <= 1'b1;
      end else begin
         int_n_q <= vertical_retrace_int_n;
         if (int_n_q && !vertical_retrace_int_n) begin
            fire_phase <= ~fire_phase;   // Once per frame
         end
      end
   end

   // Fire passes only in the open phase when autofire is on
   assign kbd_state = {kbdjoy_in[4] & (fire_phase | ~kbd_autofire), kbdjoy_in[3:0]};
   assign db9_state = {~db9joy_in[4] & (fire_phase | ~db9_autofire), ~db9joy_in[3:0]};

   //////////////////////////////////////////////////////////////////////
   // Kempston port
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      kemp_bits = '0;
      if (kbd_mode == zxuno_pkg::JOY_KEMPSTON)
         kemp_bits = kemp_bits | kbd_state;
      if (db9_mode == zxuno_pkg::JOY_KEMPSTON)
         kemp_bits = kemp_bits | db9_state;
   end

   assign dout = {3'b000, kemp_bits};   // 000FUDLR
   assign oe_n = !((a[7:0] == `KEMPSTON_PORT) && !iorq_n && !rd_n && wr_n);

   //////////////////////////////////////////////////////////////////////
   // Key injection
   //////////////////////////////////////////////////////////////////////

   // Which column bits one joystick holds down for the current rows
   function automatic logic [4:0] key_mask(input zxuno_pkg::joy_mode_t mode,
                                           input logic [4:0] st,
                                           input logic row12_n,
                                           input logic row11_n);
      logic [4:0] m;
      m = '0;
      case (mode)
         zxuno_pkg::JOY_SINCLAIR1: begin
            // Keys 6 7 8 9 0 row
            if (!row12_n)
               m = {st[1], st[0], st[2], st[3], st[4]};
         end
         zxuno_pkg::JOY_CURSOR: begin
            if (!row12_n)
               m = {st[2], st[3], st[0], 1'b0, st[4]};
            // Key 5 on the other half row
            if (!row11_n)
               m[4] = m[4] | st[1];
         end
         default: m = '0;
      endcase
      return m;
   endfunction

   assign kbd_mask = key_mask(kbd_mode, kbd_state, a[12], a[11]);
   assign db9_mask = key_mask(db9_mode, db9_state, a[12], a[11]);

   assign kbdcol_out = kbdcol_in & ~(kbd_mask | db9_mask);   // Active low columns

endmodule

// ==== source/zxuno_addr_reg.sv ====
`timescale 1ns/1ps

`include "zxuno_defines.svh"

module zxuno_addr_reg (
   input  logic                 clk,
   input  logic                 rst_n,
   // Z80 bus
   input  logic [15:0]          a,
   input  logic                 iorq_n,
   input  logic                 rd_n,
   input  logic                 wr_n,
   input  logic [7:0]           din,
   // Towards the register bank
   output zxuno_pkg::reg_addr_t zxuno_addr,       // Selected register
   output logic                 regaddr_changed,  // Pulse after a select
   output logic                 zxuno_regrd,      // Data port read level
   output logic                 zxuno_regwr,      // Data port write pulse
   // Readback of the select register
   output logic [7:0]           dout,
   output logic                 oe_n
);

   logic addr_sel;    // Address matches 0xFC3B
   logic data_sel;    // Address matches 0xFD3B
   logic addr_wr;     // Write cycle on 0xFC3B
   logic data_wr;     // Write cycle on 0xFD3B
   logic addr_wr_q;   // Previous clock value
   logic data_wr_q;
   logic addr_wr_first;  // First clock of the write

   //////////////////////////////////////////////////////////////////////
   // Port decode
   //////////////////////////////////////////////////////////////////////

   assign addr_sel = (a == `ZXUNO_ADDR_PORT);
   assign data_sel = (a == `ZXUNO_DATA_PORT);

   assign addr_wr = addr_sel && !iorq_n && !wr_n;
   assign data_wr = data_sel && !iorq_n && !wr_n;

   // Reads are plain combinational decodes
   assign zxuno_regrd = data_sel && !iorq_n && !rd_n && wr_n;

   assign dout = zxuno_addr;
   assign oe_n = !(addr_sel && !iorq_n && !rd_n && wr_n);

   //////////////////////////////////////////////////////////////////////
   // Write edge detection
   //////////////////////////////////////////////////////////////////////

   assign addr_wr_first = addr_wr && !addr_wr_q;
   assign zxuno_regwr   = data_wr && !data_wr_q;   // One clock per write cycle

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         addr_wr_q       <= 1'b0;
         data_wr_q       <= 1'b0;
         zxuno_addr      <= '0;
         regaddr_changed <= 1'b0;
      end else begin
         addr_wr_q <= addr_wr;
         data_wr_q <= data_wr;
         // New register number flagged on the following clock
         if (addr_wr_first) begin
            zxuno_addr <= din;
         end
         regaddr_changed <= addr_wr_first;
      end
   end

endmodule

// ==== source/zxuno_bus.sv ====
`timescale 1ns/1ps

module zxuno_bus (
   input  logic        clk,
   input  logic        rst_n,
   // Z80 bus
   input  logic [15:0] a,
   input  logic        iorq_n,
   input  logic        rd_n,
   input  logic        wr_n,
   input  logic [7:0]  din,
   output logic [7:0]  dout,
   output logic        oe_n,
   // Joysticks and keyboard
   input  logic [4:0]  kbdjoy_in,
   input  logic [4:0]  db9joy_in,
   input  logic [4:0]  kbdcol_in,
   output logic [4:0]  kbdcol_out,
   input  logic        vertical_retrace_int_n
);

   // Register bank control
   zxuno_pkg::reg_addr_t zxuno_addr;
   logic                 regaddr_changed;
   logic                 zxuno_regrd;
   logic                 zxuno_regwr;

   // Per source read data
   logic [7:0] addr_dout;
   logic       oe_n_addr;
   logic [7:0] coreid_dout;
   logic       oe_n_coreid;
   logic [7:0] joyconf_dout;
   logic       oe_n_joyconf;
   logic [7:0] joystick_dout;
   logic       oe_n_joystick;

   // JOYCONF fields
   zxuno_pkg::joy_mode_t kbd_mode;
   zxuno_pkg::joy_mode_t db9_mode;
   logic                 kbd_autofire;
   logic                 db9_autofire;

   zxuno_addr_reg i_addr_reg (
      .clk(clk), .rst_n(rst_n),
      .a(a), .iorq_n(iorq_n), .rd_n(rd_n), .wr_n(wr_n), .din(din),
      .zxuno_addr(zxuno_addr), .regaddr_changed(regaddr_changed),
      .zxuno_regrd(zxuno_regrd), .zxuno_regwr(zxuno_regwr),
      .dout(addr_dout), .oe_n(oe_n_addr)
   );

   coreid i_coreid (
      .clk(clk), .rst_n(rst_n),
      .zxuno_addr(zxuno_addr), .zxuno_regrd(zxuno_regrd),
      .regaddr_changed(regaddr_changed),
      .dout(coreid_dout), .oe_n(oe_n_coreid)
   );

   joy_config i_joy_config (
      .clk(clk), .rst_n(rst_n),
      .zxuno_addr(zxuno_addr), .zxuno_regrd(zxuno_regrd), .zxuno_regwr(zxuno_regwr),
      .din(din), .dout(joyconf_dout), .oe_n(oe_n_joyconf),
      .kbd_mode(kbd_mode), .kbd_autofire(kbd_autofire),
      .db9_mode(db9_mode), .db9_autofire(db9_autofire)
   );

   joystick_mapper i_joystick_mapper (
      .clk(clk), .rst_n(rst_n),
      .a(a), .iorq_n(iorq_n), .rd_n(rd_n), .wr_n(wr_n),
      .kbdjoy_in(kbdjoy_in), .db9joy_in(db9joy_in),
      .kbdcol_in(kbdcol_in), .kbdcol_out(kbdcol_out),
      .vertical_retrace_int_n(vertical_retrace_int_n),
      .kbd_mode(kbd_mode), .kbd_autofire(kbd_autofire),
      .db9_mode(db9_mode), .db9_autofire(db9_autofire),
      .dout(joystick_dout), .oe_n(oe_n_joystick)
   );

   // Fixed priority with the floating bus read as 0xFF
   assign dout = !oe_n_addr     ? addr_dout     :
                 !oe_n_coreid   ? coreid_dout   :
                 !oe_n_joyconf  ? joyconf_dout  :
                 !oe_n_joystick ? joystick_dout :
                                  8'hFF;

   assign oe_n = oe_n_addr & oe_n_coreid & oe_n_joyconf & oe_n_joystick;

endmodule

// ==== source/zxuno_defines.svh ====
`ifndef ZXUNO_DEFINES_SVH
`define ZXUNO_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// I/O port decode
//////////////////////////////////////////////////////////////////////

// ZX-Uno register select and data ports with full 16-bit decode
`define ZXUNO_ADDR_PORT 16'hFC3B
`define ZXUNO_DATA_PORT 16'hFD3B

// Kempston joystick decodes only the low byte
`define KEMPSTON_PORT 8'h1F

//////////////////////////////////////////////////////////////////////
// Internal register numbers
//////////////////////////////////////////////////////////////////////

`define REG_JOYCONF 8'h06
`define REG_COREID  8'hFF

// Both joysticks Kempston with autofire off
`define JOYCONF_RESET 8'h11

// "T01-2024" plus zero terminator
`define COREID_LEN 9

`endif

// ==== source/zxuno_pkg.sv ====
package zxuno_pkg;

   //////////////////////////////////////////////////////////////////////
   // Joystick modes
   //////////////////////////////////////////////////////////////////////

   // Three bit field in JOYCONF for each joystick
   // Codes 4 to 7 are treated as off by the decoder
   typedef enum logic [2:0] {
      JOY_OFF       = 3'd0,   // Joystick ignored
      JOY_KEMPSTON  = 3'd1,   // Port 0x1F
      JOY_SINCLAIR1 = 3'd2,   // Keys 6-0 row
      JOY_CURSOR    = 3'd3    // Keys 5-8 and 0
   } joy_mode_t;

   //////////////////////////////////////////////////////////////////////
   // Register numbers
   //////////////////////////////////////////////////////////////////////

   // Value held by the 0xFC3B register
   typedef logic [7:0] reg_addr_t;

endpackage

// ==== zxuno_bus.f ====
+incdir+source
source/zxuno_pkg.sv
source/zxuno_addr_reg.sv
source/coreid.sv
source/joy_config.sv
source/joystick_mapper.sv
source/zxuno_bus.sv
bench/zxuno_bus_chk.sv
bench/zxuno_bus_tb.sv
